// ==== logic/dmdPkg.sv ====
package dmdPkg;

	// One stored dot, RGB332
	typedef logic [7:0] dotByte;

	// One LCD colour channel
	typedef logic [5:0] chan6;

	// One 7-bit LVDS lane word
	typedef logic [6:0] lvdsWord;

	// Horizontal and vertical raster counters
	typedef logic [15:0] lineCount;

	// Value of one setting register
	typedef logic [15:0] settingWord;

	// Routing of an assembled serial byte, decoded from dotReg
	typedef enum logic {
		dotToPixel   = 1'b0,
		dotToSetting = 1'b1
	} dotTarget;

	// Setting register slots, in the order the pairs arrive
	typedef enum logic [1:0] {
		setStartLine  = 2'd0,
		setDotRows    = 2'd1,
		setBrightness = 2'd2
	} settingIndex;

	// Order of the two frame memory reads in each slot
	typedef enum logic [1:0] {
		fetchIdle = 2'd0,
		fetchEven = 2'd1,
		fetchOdd  = 2'd2
	} fetchState;

	// Pattern driven on both LVDS clock pairs
	localparam lvdsWord ClockPattern = 7'b1100011;

endpackage

// ==== logic/backlightPwm.sv ====
`timescale 1ns/100ps

module backlightPwm
	import dmdPkg::*;
#(
	parameter int PwmTop = 250
)
(
	input  logic clock,
	input  logic reset,
	input  settingWord brightness,
	output logic backlightPwm
);

	settingWord pwmCount;	// Runs 0 to PwmTop

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pwmCount <= '0;
			backlightPwm <= 1'b0;
		end
		else
		begin
			pwmCount <= (pwmCount == settingWord'(PwmTop)) ? '0 : pwmCount + 1'b1;
			backlightPwm <= (pwmCount <= brightness);	// brightness + 1 high clocks
		end
	end

endmodule

// ==== logic/frameBuffer.sv ====
`timescale 1ns/100ps

module frameBuffer
	import dmdPkg::*;
#(
	parameter int DotCols = 128,
	parameter int MaxDotRows = 64,
	localparam int BankDepth = DotCols * MaxDotRows,
	localparam int AddrWidth = $clog2(2 * BankDepth)
)
(
	input  logic clock,
	input  logic writeEnable,
	input  logic [AddrWidth-1:0] writeAddress,
	input  dotByte writeData,
	input  logic [AddrWidth-1:0] readAddress,
	output dotByte readData
);

	// Bank 0 in the lower half, bank 1 in the upper half
	dotByte memory [0:2*BankDepth-1];

	always_ff @(posedge clock)
	begin
		if (writeEnable)
			memory[writeAddress] <= writeData;
	end

	always_ff @(posedge clock)
	begin
		readData <= memory[readAddress];	// One clock read latency
	end

endmodule

// ==== logic/rasterTiming.sv ====
`timescale 1ns/100ps

module rasterTiming
	import dmdPkg::*;
#(
	parameter int HFront = 20,
	parameter int HSync = 16,
	parameter int HBack = 34,
	parameter int HActPairs = 960,
	parameter int VFront = 3,
	parameter int VSync = 5,
	parameter int VBack = 23,
	parameter int VAct = 1080
)
(
	input  logic clock,
	input  logic reset,
	input  logic slotStart,
	output lineCount hCount,
	output lineCount vCount,
	output logic dataEnable,
	output logic hSyncN,
	output logic vSyncN
);

	localparam lineCount HSyncStart = lineCount'(HFront);
	localparam lineCount HSyncEnd = lineCount'(HFront + HSync);
	localparam lineCount HBlank = lineCount'(HFront + HSync + HBack);
	localparam lineCount HLast = lineCount'(HFront + HSync + HBack + HActPairs - 1);
	localparam lineCount VSyncStart = lineCount'(VFront);
	localparam lineCount VSyncEnd = lineCount'(VFront + VSync);
	localparam lineCount VBlank = lineCount'(VFront + VSync + VBack);
	localparam lineCount VLast = lineCount'(VFront + VSync + VBack + VAct - 1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (slotStart)
		begin
			if (hCount == HLast)
			begin
				hCount <= '0;
				vCount <= (vCount == VLast) ? '0 : vCount + 1'b1;	// Frame wraps
			end
			else
				hCount <= hCount + 1'b1;
		end
	end

	// Sync pulses sit between the front and back porches
	assign hSyncN = !((hCount >= HSyncStart) && (hCount < HSyncEnd));
	assign vSyncN = !((vCount >= VSyncStart) && (vCount < VSyncEnd));
	assign dataEnable = (hCount >= HBlank) && (vCount >= VBlank);

	// Pair count stays below the line total
	hCountRange: assert property (@(posedge clock) disable iff (reset)
		hCount <= HLast);

endmodule

// ==== logic/lvdsSerializer.sv ====
`timescale 1ns/100ps

module lvdsSerializer
	import dmdPkg::*;
(
	input  logic clock,
	input  logic reset,
	input  lvdsWord evenRx2,
	input  lvdsWord evenRx1,
	input  lvdsWord evenRx0,
	input  lvdsWord oddRx2,
	input  lvdsWord oddRx1,
	input  lvdsWord oddRx0,
	output logic slotStart,
	output logic pairEClk,
	output logic pairE2,
	output logic pairE1,
	output logic pairE0,
	output logic pairOClk,
	output logic pairO2,
	output logic pairO1,
	output logic pairO0
);

	logic [2:0] bitCount;	// Bit 6 goes out first
	lvdsWord laneHold [0:5];

	assign slotStart = (bitCount == 3'd0);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			bitCount <= 3'd6;
			laneHold <= '{default: '0};
		end
		else if (slotStart)
		begin
			bitCount <= 3'd6;
			laneHold <= '{evenRx2, evenRx1, evenRx0, oddRx2, oddRx1, oddRx0};
		end
		else
			bitCount <= bitCount - 3'd1;
	end

	assign pairEClk = ClockPattern[bitCount];
	assign pairE2 = laneHold[0][bitCount];
	assign pairE1 = laneHold[1][bitCount];
	assign pairE0 = laneHold[2][bitCount];
	assign pairOClk = ClockPattern[bitCount];
	assign pairO2 = laneHold[3][bitCount];
	assign pairO1 = laneHold[4][bitCount];
	assign pairO0 = laneHold[5][bitCount];

	bitCountRange: assert property (@(posedge clock) disable iff (reset)
		bitCount <= 3'd6);

endmodule

// ==== logic/dotPixelMapper.sv ====
`timescale 1ns/100ps

module dotPixelMapper
	import dmdPkg::*;
#(
	parameter int HFront = 20,
	parameter int HSync = 16,
	parameter int HBack = 34,
	parameter int VFront = 3,
	parameter int VSync = 5,
	parameter int VBack = 23,
	parameter int DotCols = 128,
	parameter int DotWidth = 15,
	parameter int DotHeight = 15,
	parameter int MaxDotRows = 64,
	localparam int BankDepth = DotCols * MaxDotRows,
	localparam int AddrWidth = $clog2(2 * BankDepth)
)
(
	input  logic clock,
	input  logic reset,
	input  logic slotStart,
	input  lineCount hCount,
	input  lineCount vCount,
	input  logic dataEnable,
	input  logic hSyncN,
	input  logic vSyncN,
	input  logic displayBank,
	input  settingWord startLine,
	input  settingWord dotRows,
	output logic [AddrWidth-1:0] readAddress,
	input  dotByte readData,
	output lvdsWord evenRx2,
	output lvdsWord evenRx1,
	output lvdsWord evenRx0,
	output lvdsWord oddRx2,
	output lvdsWord oddRx1,
	output lvdsWord oddRx0
);

	localparam lineCount HBlank = lineCount'(HFront + HSync + HBack);
	localparam lineCount VBlank = lineCount'(VFront + VSync + VBack);
	localparam logic [AddrWidth-1:0] BankOffset = AddrWidth'(BankDepth);

	fetchState state;
	fetchState readState;	// What readData holds this cycle
	lineCount pairIndex;
	lineCount activeLine;
	lineCount dotRow;
	lineCount evenCol;
	lineCount oddCol;
	logic [31:0] areaEnd;
	logic slotLit;
	logic [AddrWidth-1:0] rowBase;
	logic [AddrWidth-1:0] evenAddress;
	logic [AddrWidth-1:0] oddAddress;
	dotByte evenDot;
	chan6 evenRed;
	chan6 evenGreen;
	chan6 evenBlue;
	chan6 oddRed;
	chan6 oddGreen;
	chan6 oddBlue;

	assign pairIndex = hCount - HBlank;
	assign activeLine = vCount - VBlank;
	assign areaEnd = 32'(startLine) + 32'(dotRows) * 32'(DotHeight);
	assign slotLit = dataEnable && (activeLine >= startLine) && (32'(activeLine) < areaEnd);

	// Both pixels of a slot share a line, so only the column differs
	assign dotRow = (activeLine - startLine) / lineCount'(DotHeight);
	assign evenCol = {pairIndex[14:0], 1'b0} / lineCount'(DotWidth);
	assign oddCol = {pairIndex[14:0], 1'b1} / lineCount'(DotWidth);
	assign rowBase = AddrWidth'(32'(dotRow) * 32'(DotCols));
	assign evenAddress = (displayBank ? BankOffset : '0) + rowBase + AddrWidth'(evenCol);
	assign oddAddress = (displayBank ? BankOffset : '0) + rowBase + AddrWidth'(oddCol);
	assign readAddress = (state == fetchOdd) ? oddAddress : evenAddress;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= fetchIdle;
			readState <= fetchIdle;
		end
		else
		begin
			readState <= state;
			case (state)
				fetchIdle: if (slotStart) state <= fetchEven;	// Counters are new next cycle
				fetchEven: state <= fetchOdd;
				fetchOdd: state <= fetchIdle;
				default: state <= fetchIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (readState == fetchEven)
			evenDot <= readData;
	end

	// RGB332 widened to 6 bits per channel, black outside the dot area
	always_comb
	begin
		evenRed = slotLit ? {evenDot[7:5], 3'b000} : '0;
		evenGreen = slotLit ? {evenDot[4:2], 3'b000} : '0;
		evenBlue = slotLit ? {evenDot[1:0], 4'b0000} : '0;
		oddRed = slotLit ? {readData[7:5], 3'b000} : '0;
		oddGreen = slotLit ? {readData[4:2], 3'b000} : '0;
		oddBlue = slotLit ? {readData[1:0], 4'b0000} : '0;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			evenRx2 <= '0;
			evenRx1 <= '0;
			evenRx0 <= '0;
			oddRx2 <= '0;
			oddRx1 <= '0;
			oddRx0 <= '0;
		end
		else if (readState == fetchOdd)	// Odd dot is on readData now
		begin
			evenRx2 <= {dataEnable, vSyncN, hSyncN, evenBlue[5:2]};
			evenRx1 <= {evenBlue[1:0], evenGreen[5:1]};
			evenRx0 <= {evenGreen[0], evenRed};
			oddRx2 <= {dataEnable, vSyncN, hSyncN, oddBlue[5:2]};
			oddRx1 <= {oddBlue[1:0], oddGreen[5:1]};
			oddRx0 <= {oddGreen[0], oddRed};
		end
	end

endmodule

// ==== logic/dotReceiver.sv ====
`timescale 1ns/100ps

module dotReceiver
	import dmdPkg::*;
#(
	parameter int DotCols = 128,
	parameter int MaxDotRows = 64,
	parameter int PwmTop = 250,
	localparam int BankDepth = DotCols * MaxDotRows,
	localparam int AddrWidth = $clog2(2 * BankDepth)
)
(
	input  logic clock,
	input  logic reset,
	input  logic dotClock,
	input  logic dotData,
	input  logic dotLatch,
	input  logic dotReg,
	output logic writeEnable,
	output logic [AddrWidth-1:0] writeAddress,
	output dotByte writeData,
	output logic displayBank,
	output settingWord startLine,
	output settingWord dotRows,
	output settingWord brightness
);

	localparam logic [AddrWidth-1:0] BankOffset = AddrWidth'(BankDepth);

	logic clockQ;
	logic clockPrev;
	logic dataQ;
	logic latchQ;
	logic latchPrev;
	logic regQ;
	logic clockRise;
	logic latchRise;
	logic byteDone;
	logic pixelStore;
	logic highStore;
	logic settingStore;
	logic lowPending;	// High byte of a setting pair already held
	logic [2:0] bitCount;
	logic [6:0] shiftBits;
	logic [AddrWidth-1:0] byteIndex;
	settingIndex settingPtr;
	dotByte highByte;
	dotByte newByte;

	// Serial inputs are plain data on this clock
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			clockQ <= 1'b0;
			clockPrev <= 1'b0;
			dataQ <= 1'b0;
			latchQ <= 1'b0;
			latchPrev <= 1'b0;
			regQ <= 1'b0;
		end
		else
		begin
			clockQ <= dotClock;
			clockPrev <= clockQ;
			dataQ <= dotData;
			latchQ <= dotLatch;
			latchPrev <= latchQ;
			regQ <= dotReg;
		end
	end

	assign clockRise = clockQ && !clockPrev;
	assign latchRise = latchQ && !latchPrev;
	assign byteDone = clockRise && !latchQ && (bitCount == 3'd7);
	assign newByte = {shiftBits, dataQ};	// MSB first
	assign pixelStore = byteDone && (dotTarget'(regQ) == dotToPixel);
	assign highStore = byteDone && (dotTarget'(regQ) == dotToSetting) && !lowPending;
	assign settingStore = byteDone && (dotTarget'(regQ) == dotToSetting) && lowPending;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			bitCount <= '0;
			byteIndex <= '0;
			settingPtr <= setStartLine;
			lowPending <= 1'b0;
			displayBank <= 1'b0;
			writeEnable <= 1'b0;
			startLine <= '0;
			dotRows <= settingWord'(MaxDotRows);
			brightness <= settingWord'(PwmTop / 2);
		end
		else
		begin
			writeEnable <= 1'b0;
			if (latchQ)
			begin
				bitCount <= '0;
				byteIndex <= '0;
				settingPtr <= setStartLine;
				lowPending <= 1'b0;
				if (latchRise)
					displayBank <= !displayBank;	// Filled bank goes on screen
			end
			else if (clockRise)
				bitCount <= bitCount + 3'd1;

			// Writes past the end of the bank are dropped
			if (pixelStore && (byteIndex < BankOffset))
			begin
				writeEnable <= 1'b1;
				byteIndex <= byteIndex + 1'b1;
			end

			if (highStore)
				lowPending <= 1'b1;

			if (settingStore)
			begin
				case (settingPtr)
					setStartLine: startLine <= {highByte, newByte};
					setDotRows: dotRows <= {highByte, newByte};
					setBrightness: brightness <= {highByte, newByte};
					default: ;
				endcase
				settingPtr <= settingIndex'(settingPtr + 2'd1);
				lowPending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (clockRise && !latchQ)
			shiftBits <= {shiftBits[5:0], dataQ};
		if (highStore)
			highByte <= newByte;
		if (pixelStore)
		begin
			writeAddress <= (displayBank ? '0 : BankOffset) + byteIndex;	// Hidden bank
			writeData <= newByte;
		end
	end

	// The host sends at most three setting pairs per latch
	settingInRange: assert property (@(posedge clock) disable iff (reset)
		settingStore |-> (settingPtr <= setBrightness));

endmodule

// ==== logic/lcdDmdDriver.sv ====
`timescale 1ns/100ps

module lcdDmdDriver
	import dmdPkg::*;
#(
	parameter int HFront = 20,
	parameter int HSync = 16,
	parameter int HBack = 34,
	parameter int HActPairs = 960,	// Two screen pixels per pair
	parameter int VFront = 3,
	parameter int VSync = 5,
	parameter int VBack = 23,
	parameter int VAct = 1080,
	parameter int DotCols = 128,
	parameter int DotWidth = 15,
	parameter int DotHeight = 15,
	parameter int MaxDotRows = 64,
	parameter int PwmTop = 250,
	localparam int AddrWidth = $clog2(2 * DotCols * MaxDotRows)
)
(
	input  logic bit_clock_out,
	input  logic reset,
	input  logic dotClock,
	input  logic dotData,
	input  logic dotLatch,
	input  logic dotReg,
	output logic pairEClk,
	output logic pairE2,
	output logic pairE1,
	output logic pairE0,
	output logic pairOClk,
	output logic pairO2,
	output logic pairO1,
	output logic pairO0,
	output logic backlightPwm
);

	logic writeEnable;
	logic [AddrWidth-1:0] writeAddress;
	logic [AddrWidth-1:0] readAddress;
	dotByte writeData;
	dotByte readData;
	logic displayBank;
	settingWord startLine;
	settingWord dotRows;
	settingWord brightness;
	logic slotStart;
	lineCount hCount;
	lineCount vCount;
	logic dataEnable;
	logic hSyncN;
	logic vSyncN;
	lvdsWord evenRx2;
	lvdsWord evenRx1;
	lvdsWord evenRx0;
	lvdsWord oddRx2;
	lvdsWord oddRx1;
	lvdsWord oddRx0;

	// Serial dots in, frame memory writes and settings out
	dotReceiver #(
		.DotCols(DotCols),
		.MaxDotRows(MaxDotRows),
		.PwmTop(PwmTop)
	) dotReceiver_inst (
		.clock(bit_clock_out),
		.reset(reset),
		.dotClock(dotClock),
		.dotData(dotData),
		.dotLatch(dotLatch),
		.dotReg(dotReg),
		.writeEnable(writeEnable),
		.writeAddress(writeAddress),
		.writeData(writeData),
		.displayBank(displayBank),
		.startLine(startLine),
		.dotRows(dotRows),
		.brightness(brightness)
	);

	frameBuffer #(
		.DotCols(DotCols),
		.MaxDotRows(MaxDotRows)
	) frameBuffer_inst (
		.clock(bit_clock_out),
		.writeEnable(writeEnable),
		.writeAddress(writeAddress),
		.writeData(writeData),
		.readAddress(readAddress),
		.readData(readData)
	);

	rasterTiming #(
		.HFront(HFront),
		.HSync(HSync),
		.HBack(HBack),
		.HActPairs(HActPairs),
		.VFront(VFront),
		.VSync(VSync),
		.VBack(VBack),
		.VAct(VAct)
	) rasterTiming_inst (
		.clock(bit_clock_out),
		.reset(reset),
		.slotStart(slotStart),
		.hCount(hCount),
		.vCount(vCount),
		.dataEnable(dataEnable),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN)
	);

	dotPixelMapper #(
		.HFront(HFront),
		.HSync(HSync),
		.HBack(HBack),
		.VFront(VFront),
		.VSync(VSync),
		.VBack(VBack),
		.DotCols(DotCols),
		.DotWidth(DotWidth),
		.DotHeight(DotHeight),
		.MaxDotRows(MaxDotRows)
	) dotPixelMapper_inst (
		.clock(bit_clock_out),
		.reset(reset),
		.slotStart(slotStart),
		.hCount(hCount),
		.vCount(vCount),
		.dataEnable(dataEnable),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.displayBank(displayBank),
		.startLine(startLine),
		.dotRows(dotRows),
		.readAddress(readAddress),
		.readData(readData),
		.evenRx2(evenRx2),
		.evenRx1(evenRx1),
		.evenRx0(evenRx0),
		.oddRx2(oddRx2),
		.oddRx1(oddRx1),
		.oddRx0(oddRx0)
	);

	lvdsSerializer lvdsSerializer_inst (
		.clock(bit_clock_out),
		.reset(reset),
		.evenRx2(evenRx2),
		.evenRx1(evenRx1),
		.evenRx0(evenRx0),
		.oddRx2(oddRx2),
		.oddRx1(oddRx1),
		.oddRx0(oddRx0),
		.slotStart(slotStart),
		.pairEClk(pairEClk),
		.pairE2(pairE2),
		.pairE1(pairE1),
		.pairE0(pairE0),
		.pairOClk(pairOClk),
		.pairO2(pairO2),
		.pairO1(pairO1),
		.pairO0(pairO0)
	);

	backlightPwm #(
		.PwmTop(PwmTop)
	) backlightPwm_inst (
		.clock(bit_clock_out),
		.reset(reset),
		.brightness(brightness),
		.backlightPwm(backlightPwm)
	);

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/100ps

module clockGen
#(
	parameter int Period = 40,
	parameter int ResetCycles = 10
)
(
	output logic bit_clock_out,
	output logic reset
);

	initial
	begin
		bit_clock_out = 1'b0;
		forever
			#(Period / 2) bit_clock_out = !bit_clock_out;
	end

	initial
	begin
		reset = 1'b1;
		repeat (ResetCycles)
			@(posedge bit_clock_out);
		#2 reset = 1'b0;	// Same drive delay as the other inputs
	end

endmodule

// ==== verification/lcdDmdTb.sv ====
`timescale 1ns/100ps

module lcdDmdTb
	import dmdPkg::*;
();

	localparam int HFront = 2;
	localparam int HSync = 2;
	localparam int HBack = 2;
	localparam int HActPairs = 6;
	localparam int VFront = 1;
	localparam int VSync = 1;
	localparam int VBack = 1;
	localparam int VAct = 10;
	localparam int DotCols = 4;
	localparam int DotWidth = 3;
	localparam int DotHeight = 2;
	localparam int MaxDotRows = 4;
	localparam int PwmTop = 20;

	localparam int HBlank = HFront + HSync + HBack;
	localparam int HTotal = HBlank + HActPairs;
	localparam int VBlank = VFront + VSync + VBack;
	localparam int VTotal = VBlank + VAct;
	localparam int BankDepth = DotCols * MaxDotRows;
	localparam int DriveDelay = 2;
	localparam int Rounds = 5;

	// Test length in clocks: frames waited per round, serial traffic and PWM windows
	localparam int FrameClocks = HTotal * VTotal * 7;
	localparam int ByteClocks = 8 * 4;
	localparam int SerialClocks = (Rounds + 1) * ((BankDepth + 6) * ByteClocks + 6);
	localparam int TimeoutCycles = 20 + (Rounds * 4 + 2) * FrameClocks + SerialClocks
		+ Rounds * (PwmTop + 3);

	logic bit_clock_out;
	logic reset;
	logic dotClock;
	logic dotData;
	logic dotLatch;
	logic dotReg;
	logic pairEClk;
	logic pairE2;
	logic pairE1;
	logic pairE0;
	logic pairOClk;
	logic pairO2;
	logic pairO1;
	logic pairO0;
	logic backlightPwm;

	// Reference state of the display
	dotByte modelMem [0:2*BankDepth-1];
	logic modelBank;	// Bank on screen
	settingWord modelStartLine;
	settingWord modelDotRows;
	settingWord modelBrightness;
	int writeIndex;
	int seed = 32'h874c_c335;

	// Deserializer and raster tracking
	lvdsWord shiftEClk = '0;
	lvdsWord shiftE2 = '0;
	lvdsWord shiftE1 = '0;
	lvdsWord shiftE0 = '0;
	lvdsWord shiftOClk = '0;
	lvdsWord shiftO2 = '0;
	lvdsWord shiftO1 = '0;
	lvdsWord shiftO0 = '0;
	logic locked = 1'b0;
	logic prevHSyncN = 1'b0;
	logic pictureValid = 1'b0;
	int posH = 0;
	int posV = 0;
	int frameCount = 0;
	int slotsChecked = 0;
	int pixelsChecked = 0;
	int cycleCount = 0;

	clockGen #(
		.Period(40),
		.ResetCycles(10)
	) clockGen_inst (
		.bit_clock_out(bit_clock_out),
		.reset(reset)
	);

	lcdDmdDriver #(
		.HFront(HFront),
		.HSync(HSync),
		.HBack(HBack),
		.HActPairs(HActPairs),
		.VFront(VFront),
		.VSync(VSync),
		.VBack(VBack),
		.VAct(VAct),
		.DotCols(DotCols),
		.DotWidth(DotWidth),
		.DotHeight(DotHeight),
		.MaxDotRows(MaxDotRows),
		.PwmTop(PwmTop)
	) lcdDmdDriver_inst (
		.bit_clock_out(bit_clock_out),
		.reset(reset),
		.dotClock(dotClock),
		.dotData(dotData),
		.dotLatch(dotLatch),
		.dotReg(dotReg),
		.pairEClk(pairEClk),
		.pairE2(pairE2),
		.pairE1(pairE1),
		.pairE0(pairE0),
		.pairOClk(pairOClk),
		.pairO2(pairO2),
		.pairO1(pairO1),
		.pairO0(pairO0),
		.backlightPwm(backlightPwm)
	);

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input lvdsWord got, input lvdsWord expected);
		if (got !== expected)
			reportFailure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	task automatic checkChan(input string name, input chan6 got, input chan6 expected);
		if (got !== expected)
			reportFailure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	task automatic checkPwm(input string name, input settingWord got, input settingWord expected);
		if (got !== expected)
			reportFailure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	function automatic int randomBelow(input int limit);
		return int'($unsigned($random(seed)) % limit);
	endfunction

	// Colour of one screen pixel from the stored dots and settings
	task automatic expectPixel(input int x, input int line, input logic active,
		output chan6 red, output chan6 green, output chan6 blue);
		int areaEnd;
		int address;
		dotByte dot;
		areaEnd = int'(modelStartLine) + int'(modelDotRows) * DotHeight;
		red = '0;
		green = '0;
		blue = '0;
		if (active && (line >= int'(modelStartLine)) && (line < areaEnd))
		begin
			address = int'(modelBank) * BankDepth
				+ ((line - int'(modelStartLine)) / DotHeight) * DotCols + x / DotWidth;
			dot = modelMem[address];
			red = {dot[7:5], 3'b000};
			green = {dot[4:2], 3'b000};
			blue = {dot[1:0], 4'b0000};
		end
	endtask

	task automatic comparePixel(input string side, input lvdsWord lane2, input lvdsWord lane1,
		input lvdsWord lane0, input int x, input logic active);
		chan6 redExp;
		chan6 greenExp;
		chan6 blueExp;
		string where;
		expectPixel(x, posV - VBlank, active, redExp, greenExp, blueExp);
		where = $sformatf("%s pixel x %0d line %0d", side, x, posV - VBlank);
		checkChan({where, " red"}, lane0[5:0], redExp);
		checkChan({where, " green"}, {lane1[4:0], lane0[6]}, greenExp);
		checkChan({where, " blue"}, {lane2[3:0], lane1[6:5]}, blueExp);
		pixelsChecked++;
	endtask

	// One received slot, raster position tracked from the lock point on
	task automatic checkSlot();
		logic activeExp;
		logic vSyncExp;
		logic hSyncExp;
		lvdsWord controlExp;
		if (!locked && prevHSyncN && !shiftE2[4] && !shiftE2[5])
		begin
			locked = 1'b1;	// First hSync fall inside vSync
			posH = HFront;
			posV = VFront;
		end
		prevHSyncN = shiftE2[4];
		if (locked)
		begin
			if ((posH == 0) && (posV == 0))
				frameCount++;
			activeExp = (posH >= HBlank) && (posV >= VBlank);
			vSyncExp = !((posV >= VFront) && (posV < VFront + VSync));
			hSyncExp = !((posH >= HFront) && (posH < HFront + HSync));
			controlExp = {activeExp, vSyncExp, hSyncExp, 4'b0000};
			checkWord("pairOClk", shiftOClk, ClockPattern);
			checkWord("pairE2 control bits", shiftE2 & 7'b1110000, controlExp);
			checkWord("pairO2 control bits", shiftO2 & 7'b1110000, controlExp);
			if (pictureValid)
			begin
				comparePixel("even", shiftE2, shiftE1, shiftE0, 2 * (posH - HBlank), activeExp);
				comparePixel("odd", shiftO2, shiftO1, shiftO0, 2 * (posH - HBlank) + 1, activeExp);
			end
			slotsChecked++;
			posH++;
			if (posH == HTotal)
			begin
				posH = 0;
				posV = (posV == VTotal - 1) ? 0 : posV + 1;
			end
		end
	endtask

	// Lanes are stable around the falling edge
	always @(negedge bit_clock_out)
	begin
		shiftEClk = {shiftEClk[5:0], pairEClk};
		shiftE2 = {shiftE2[5:0], pairE2};
		shiftE1 = {shiftE1[5:0], pairE1};
		shiftE0 = {shiftE0[5:0], pairE0};
		shiftOClk = {shiftOClk[5:0], pairOClk};
		shiftO2 = {shiftO2[5:0], pairO2};
		shiftO1 = {shiftO1[5:0], pairO1};
		shiftO0 = {shiftO0[5:0], pairO0};
		if (!reset && (shiftEClk === ClockPattern))
			checkSlot();
	end

	always @(posedge bit_clock_out)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
			reportFailure($sformatf("Timeout after %0d clocks, the tests did not finish",
				cycleCount));
	end

	task automatic stepClocks(input int count);
		repeat (count)
			@(posedge bit_clock_out);
		#(DriveDelay);
	endtask

	// Each input holds 2 clocks so the receiver sees every edge
	task automatic sendByte(input dotTarget target, input dotByte value);
		dotReg = (target == dotToSetting);
		for (int i = 7; i >= 0; i--)
		begin
			dotData = value[i];
			dotClock = 1'b0;
			stepClocks(2);
			dotClock = 1'b1;
			stepClocks(2);
		end
		dotClock = 1'b0;
	endtask

	task automatic loadBank();
		dotByte value;
		repeat (BankDepth)
		begin
			value = dotByte'(randomBelow(256));
			sendByte(dotToPixel, value);
			modelMem[int'(!modelBank) * BankDepth + writeIndex] = value;	// Hidden bank
			writeIndex++;
		end
		stepClocks(2);
	endtask

	task automatic sendSetting(input settingIndex which, input settingWord value);
		sendByte(dotToSetting, value[15:8]);
		sendByte(dotToSetting, value[7:0]);
		case (which)
			setStartLine: modelStartLine = value;
			setDotRows: modelDotRows = value;
			default: modelBrightness = value;
		endcase
	endtask

	task automatic randomSettings();
		sendSetting(setStartLine, settingWord'(randomBelow(VAct)));
		sendSetting(setDotRows, settingWord'(randomBelow(MaxDotRows + 1)));
		sendSetting(setBrightness, settingWord'(randomBelow(PwmTop + 1)));
		stepClocks(2);
	endtask

	task automatic latchFrame();
		dotLatch = 1'b1;
		stepClocks(3);
		dotLatch = 1'b0;
		stepClocks(3);
		modelBank = !modelBank;
		writeIndex = 0;
	endtask

	task automatic waitFrameStart();
		int target;
		target = frameCount + 1;
		wait (frameCount >= target);
		stepClocks(1);
	endtask

	// High clocks over one full PWM period
	task automatic checkBacklight();
		int highCount;
		highCount = 0;
		repeat (PwmTop + 1)
		begin
			@(negedge bit_clock_out);
			if (backlightPwm)
				highCount++;
		end
		checkPwm("backlightPwm high clocks", settingWord'(highCount), modelBrightness + 1'b1);
		stepClocks(1);
	endtask

	initial
	begin
		dotClock = 1'b0;
		dotData = 1'b0;
		dotLatch = 1'b0;
		dotReg = 1'b0;
		modelBank = 1'b0;
		modelStartLine = '0;
		modelDotRows = settingWord'(MaxDotRows);
		modelBrightness = settingWord'(PwmTop / 2);
		writeIndex = 0;
		@(negedge reset);
		stepClocks(2);
		loadBank();
		for (int round = 0; round < Rounds; round++)
		begin
			pictureValid = 1'b0;
			if (round > 0)
				randomSettings();	// Round 0 keeps the reset values
			latchFrame();
			waitFrameStart();
			pictureValid = 1'b1;
			loadBank();	// Goes to the hidden bank and must stay invisible
			waitFrameStart();
			waitFrameStart();
			checkBacklight();
		end
		$display("%0d slots and %0d pixels compared over %0d frames", slotsChecked,
			pixelsChecked, frameCount);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== sim.f ====
logic/dmdPkg.sv
logic/backlightPwm.sv
logic/frameBuffer.sv
logic/rasterTiming.sv
logic/lvdsSerializer.sv
logic/dotPixelMapper.sv
logic/dotReceiver.sv
logic/lcdDmdDriver.sv
verification/clockGen.sv
verification/lcdDmdTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= lcdDmdTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= sim.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
